// ==== design/obj_draw.sv ====
// Sprite draw unit, fetches ROM pixel words and writes zoomed, flipped pixels to the line buffer
`default_nettype none

module obj_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hstart,
    input  logic        start,
    output logic        busy,
    input  logic [8:0]  xpos,
    input  logic [17:0] addr,
    input  logic [1:0]  prio,
    input  logic        shadow,
    input  logic [6:0]  pal,
    input  logic [4:0]  hzoom,
    input  logic        hflip,
    input  logic        backwd,
    input  logic        obj_ok,
    output logic        obj_cs,
    output logic [17:0] obj_addr,
    input  logic [31:0] obj_data,
    output logic        bf_we,
    output logic [8:0]  bf_addr,
    output logic [13:0] bf_data
);
    draw_state_t state;
    logic [17:0] cur;          // Word address, bank bits stay fixed
    logic [31:0] pxl_data;     // Pixels left in the word
    logic [2:0]  cnt;
    logic [8:0]  pos;          // Next line buffer position
    logic [5:0]  hzacc;
    logic [6:0]  hzsum;
    logic        drop;
    logic        load;
    logic        step;
    logic        last_data;
    logic [3:0]  head;         // Pixel handled this cycle
    logic [1:0]  prio_r;
    logic        shadow_r;
    logic [6:0]  pal_r;
    logic [4:0]  hzoom_r;
    logic        hflip_r;
    logic        backwd_r;

    assign load = state == DRAW_FETCH && obj_ok;
    assign step = load || state == DRAW_PIXELS;
    // First pixel comes straight off the ROM bus
    assign head = load ? (hflip_r ? obj_data[3:0] : obj_data[31:28])
                       : (hflip_r ? pxl_data[3:0] : pxl_data[31:28]);
    assign hzsum    = {1'b0, hzacc} + {2'b00, hzoom_r};
    assign drop     = hzsum[6];        // Zoom carry skips the pixel
    assign obj_addr = cur;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= DRAW_IDLE;
            busy   <= 1'b0;
            obj_cs <= 1'b0;
            bf_we  <= 1'b0;
        end else if (hstart) begin
            state  <= DRAW_IDLE;     // Unfinished sprite is dropped
            busy   <= 1'b0;
            obj_cs <= 1'b0;
            bf_we  <= 1'b0;
        end else begin
            bf_we <= step && !drop && head != TRANSP;
            case (state)
                DRAW_IDLE: if (start) begin
                    busy   <= 1'b1;
                    obj_cs <= 1'b1;
                    state  <= DRAW_FETCH;
                end
                DRAW_FETCH: if (obj_ok) begin
                    obj_cs <= 1'b0;
                    state  <= DRAW_PIXELS;
                end
                DRAW_PIXELS: if (cnt == 3'd7) state <= DRAW_WAIT;
                DRAW_WAIT: begin
                    if (last_data) begin
                        busy  <= 1'b0;     // End marker seen
                        state <= DRAW_IDLE;
                    end else begin
                        obj_cs <= 1'b1;
                        state  <= DRAW_FETCH;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DRAW_IDLE && start) begin
            cur      <= addr;
            pos      <= xpos;
            hzacc    <= {hzoom[3:0], 2'b00};
            prio_r   <= prio;
            shadow_r <= shadow;
            pal_r    <= pal;
            hzoom_r  <= hzoom;
            hflip_r  <= hflip;
            backwd_r <= backwd;
        end
        if (load) begin
            pxl_data <= hflip_r ? obj_data >> 4 : obj_data << 4;
            cnt      <= 3'd1;
        end else if (state == DRAW_PIXELS) begin
            pxl_data <= hflip_r ? pxl_data >> 4 : pxl_data << 4;
            cnt      <= cnt + 3'd1;
        end
        if (step) begin
            bf_addr <= pos;
            bf_data <= {pal_r, shadow_r, prio_r, head};
            hzacc   <= hzsum[5:0];
            if (!drop) pos <= backwd_r ? pos - 9'd1 : pos + 9'd1;
        end
        // Last pixel in drawing order decides if the sprite goes on
        if (state == DRAW_PIXELS && cnt == 3'd7) last_data <= head == TRANSP;
        if (state == DRAW_WAIT && !last_data) begin
            cur[15:0] <= hflip_r ? cur[15:0] - 16'd1 : cur[15:0] + 16'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) bf_we |-> busy);

endmodule

`default_nettype wire

// ==== design/obj_line_buf.sv ====
// Sprite line buffer, two halves swapped each line with priority writes and clear-on-read output
`default_nettype none

module obj_line_buf import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hstart,
    input  logic [NUM_DRAW-1:0]    we,
    input  logic [NUM_DRAW*9-1:0]  waddr,
    input  logic [NUM_DRAW*14-1:0] wdata,
    input  logic [8:0]             rd_addr,
    output logic [13:0]            rd_data
);
    logic [13:0]         mem [2*LINE_W];  // Upper address bit picks the half
    logic                half;            // Half being drawn
    logic [NUM_DRAW-1:0] land;            // Write passes the priority check

    always_comb begin
        logic [13:0] stored;
        for (int i = 0; i < NUM_DRAW; i++) begin
            stored  = mem[{half, waddr[i*9 +: 9]}];
            // Empty spot or equal and higher prio overwrite
            land[i] = we[i] && (stored[3:0] == TRANSP || wdata[i*14+4 +: 2] >= stored[5:4]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half    <= 1'b0;
            rd_data <= BF_CLEAR;
            for (int a = 0; a < 2*LINE_W; a++) begin
                mem[a] <= BF_CLEAR;
            end
        end else begin
            if (hstart) half <= ~half;
            // Display side, read and wipe for the next use
            rd_data                 <= mem[{~half, rd_addr}];
            mem[{~half, rd_addr}]   <= BF_CLEAR;
            // Highest index first so unit 0 has the last word on a collision
            for (int i = NUM_DRAW - 1; i >= 0; i--) begin
                if (land[i]) mem[{half, waddr[i*9 +: 9]}] <= wdata[i*14 +: 14];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/obj_pkg.sv ====
// Sprite layer shared constants, sprite table layout and FSM state types
`default_nettype none

package obj_pkg;

    localparam int NUM_DRAW   = 3;                  // Draw units in the bank
    localparam int DRAW_IDX_W = $clog2(NUM_DRAW);
    localparam int NUM_SPR    = 16;                 // Sprite table entries
    localparam int LINE_W     = 512;                // Pixels per line buffer half

    localparam logic [3:0]  TRANSP   = 4'hf;        // Transparent nibble
    localparam logic [13:0] BF_CLEAR = {10'd0, TRANSP};

    // Sprite table word, LSB first
    localparam int F_YPOS_LSB   = 0;
    localparam int F_YPOS_W     = 8;
    localparam int F_HEIGHT_LSB = 8;
    localparam int F_HEIGHT_W   = 8;
    localparam int F_XPOS_LSB   = 16;
    localparam int F_XPOS_W     = 9;
    localparam int F_OFFSET_LSB = 25;
    localparam int F_OFFSET_W   = 16;               // Word address inside the bank
    localparam int F_BANK_LSB   = 41;
    localparam int F_BANK_W     = 2;
    // Words per sprite row, three bits so the whole entry fits in 64
    localparam int F_STRIDE_LSB = 43;
    localparam int F_STRIDE_W   = 3;
    localparam int F_PRIO_LSB   = 46;
    localparam int F_PRIO_W     = 2;
    localparam int F_SHADOW     = 48;
    localparam int F_PAL_LSB    = 49;
    localparam int F_PAL_W      = 7;
    localparam int F_HZOOM_LSB  = 56;
    localparam int F_HZOOM_W    = 5;
    localparam int F_HFLIP      = 61;
    localparam int F_BACKWD     = 62;
    localparam int F_ENABLE     = 63;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_CHECK,
        SCAN_WAIT,
        SCAN_DONE
    } scan_state_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FETCH,     // Request out, waiting for the ROM word
        DRAW_WAIT,      // End of word, decide between next fetch and stop
        DRAW_PIXELS
    } draw_state_t;

endpackage

`default_nettype wire

// ==== design/obj_rom_arb.sv ====
// Graphics ROM arbiter that shares one chip-select/ok port among the draw units round-robin
`default_nettype none

module obj_rom_arb import obj_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_DRAW-1:0]    obj_cs,
    input  logic [NUM_DRAW*18-1:0] obj_addr,
    output logic [NUM_DRAW-1:0]    obj_ok,
    output logic                   rom_cs,
    output logic [19:2]            rom_addr,
    input  logic                   rom_ok
);
    logic [NUM_DRAW-1:0]   grant;
    logic [NUM_DRAW-1:0]   pick;
    logic [DRAW_IDX_W-1:0] last;      // Unit served most recently
    logic [DRAW_IDX_W-1:0] sel;

    // Nearest requester after the last grant wins
    always_comb begin
        int k;
        pick = '0;
        sel  = last;
        for (int n = NUM_DRAW; n >= 1; n--) begin
            k = (int'(last) + n) % NUM_DRAW;
            if (obj_cs[k]) begin
                pick    = '0;
                pick[k] = 1'b1;
                sel     = DRAW_IDX_W'(k);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
            last  <= DRAW_IDX_W'(NUM_DRAW - 1);   // Unit 0 goes first
        end else if (|grant) begin
            if (rom_ok) grant <= '0;
        end else if (|obj_cs) begin
            grant <= pick;
            last  <= sel;
        end
    end

    // Latched so the ROM sees a steady address for the whole access
    always_ff @(posedge clk) begin
        if (grant == '0 && |obj_cs) rom_addr <= obj_addr[sel*18 +: 18];
    end

    assign rom_cs = |grant;
    assign obj_ok = grant & obj_cs & {NUM_DRAW{rom_ok}};

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

`default_nettype wire

// ==== design/obj_scan.sv ====
// Sprite table scanner that picks sprites on the render line and hands them to free draw units
`default_nettype none

module obj_scan import obj_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                hstart,
    input  logic [7:0]          vrender,
    input  logic                tbl_we,
    input  logic [3:0]          tbl_addr,
    input  logic [63:0]         tbl_wdata,
    input  logic [NUM_DRAW-1:0] busy,
    output logic [NUM_DRAW-1:0] start,
    output logic [8:0]          xpos,
    output logic [17:0]         addr,
    output logic [1:0]          prio,
    output logic                shadow,
    output logic [6:0]          pal,
    output logic [4:0]          hzoom,
    output logic                hflip,
    output logic                backwd,
    output logic                scan_done
);
    logic [63:0]         tbl [NUM_SPR];
    logic [63:0]         ent;          // Entry under test
    logic [3:0]          idx;
    scan_state_t         state;
    logic [7:0]          row;          // Sprite row crossed by the line
    logic                visible;
    logic [15:0]         row_ofs;
    logic [NUM_DRAW-1:0] idle;
    logic [NUM_DRAW-1:0] free_oh;      // Lowest idle unit
    logic                dispatch;

    // Wraps modulo 256 so sprites can straddle the top edge
    assign row     = vrender - ent[F_YPOS_LSB +: F_YPOS_W];
    assign visible = ent[F_ENABLE] && row < ent[F_HEIGHT_LSB +: F_HEIGHT_W];
    assign row_ofs = ent[F_OFFSET_LSB +: F_OFFSET_W]
                   + 16'(row) * 16'(ent[F_STRIDE_LSB +: F_STRIDE_W]);

    assign idle     = ~busy;
    assign free_oh  = idle & (~idle + NUM_DRAW'(1));   // Isolate lowest set bit
    assign dispatch = (state == SCAN_WAIT || (state == SCAN_CHECK && visible)) && |idle;

    // Last start pulse still on its way to a unit
    assign scan_done = state == SCAN_DONE && start == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SCAN_IDLE;
            idx   <= '0;
            start <= '0;
            for (int i = 0; i < NUM_SPR; i++) begin
                tbl[i] <= '0;
            end
        end else begin
            if (tbl_we) tbl[tbl_addr] <= tbl_wdata;
            start <= dispatch ? free_oh : '0;
            if (hstart) begin
                state <= SCAN_READ;    // New line restarts the walk
                idx   <= '0;
                start <= '0;
            end else begin
                case (state)
                    SCAN_READ: state <= SCAN_CHECK;
                    SCAN_CHECK, SCAN_WAIT: begin
                        if (dispatch || (state == SCAN_CHECK && !visible)) begin
                            if (idx == 4'(NUM_SPR - 1)) begin
                                state <= SCAN_DONE;
                            end else begin
                                idx   <= idx + 4'd1;
                                state <= SCAN_READ;
                            end
                        end else begin
                            state <= SCAN_WAIT;    // Every unit busy
                        end
                    end
                    default: state <= state;       // Idle and done hold until hstart
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_READ) ent <= tbl[idx];
        if (dispatch) begin
            xpos   <= ent[F_XPOS_LSB +: F_XPOS_W];
            addr   <= {ent[F_BANK_LSB +: F_BANK_W], row_ofs};
            prio   <= ent[F_PRIO_LSB +: F_PRIO_W];
            shadow <= ent[F_SHADOW];
            pal    <= ent[F_PAL_LSB +: F_PAL_W];
            hzoom  <= ent[F_HZOOM_LSB +: F_HZOOM_W];
            hflip  <= ent[F_HFLIP];
            backwd <= ent[F_BACKWD];
        end
    end

    // One unit at a time, and only one that was idle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(start) && (start & busy) == '0);

endmodule

`default_nettype wire

// ==== design/obj_top.sv ====
// Sprite layer top, scanner, draw unit bank, ROM arbiter and line buffer
`default_nettype none

module obj_top import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        hstart,
    input  logic [7:0]  vrender,
    input  logic        tbl_we,
    input  logic [3:0]  tbl_addr,
    input  logic [63:0] tbl_wdata,
    output logic        rom_cs,
    output logic [19:2] rom_addr,
    input  logic        rom_ok,
    input  logic [31:0] rom_data,
    input  logic [8:0]  rd_addr,
    output logic [13:0] rd_data,
    output logic        done
);
    logic [NUM_DRAW-1:0]    start;
    logic [NUM_DRAW-1:0]    busy;
    logic [NUM_DRAW-1:0]    obj_cs;
    logic [NUM_DRAW-1:0]    obj_ok;
    logic [NUM_DRAW-1:0]    bf_we;
    logic [NUM_DRAW*18-1:0] obj_addr;
    logic [NUM_DRAW*9-1:0]  bf_addr;
    logic [NUM_DRAW*14-1:0] bf_data;
    logic [8:0]             xpos;
    logic [17:0]            addr;      // Row word address with bank
    logic [1:0]             prio;
    logic                   shadow;
    logic [6:0]             pal;
    logic [4:0]             hzoom;
    logic                   hflip;
    logic                   backwd;
    logic                   scan_done;

    obj_scan u_scan (
        .clk, .rst, .hstart, .vrender, .tbl_we, .tbl_addr, .tbl_wdata,
        .busy, .start, .xpos, .addr, .prio, .shadow, .pal, .hzoom, .hflip, .backwd,
        .scan_done
    );

    // Fields are shared, start picks the unit
    for (genvar i = 0; i < NUM_DRAW; i++) begin : g_draw
        obj_draw u_draw (
            .clk, .rst, .hstart,
            .start(start[i]), .busy(busy[i]),
            .xpos, .addr, .prio, .shadow, .pal, .hzoom, .hflip, .backwd,
            .obj_ok(obj_ok[i]), .obj_cs(obj_cs[i]),
            .obj_addr(obj_addr[i*18 +: 18]), .obj_data(rom_data),
            .bf_we(bf_we[i]), .bf_addr(bf_addr[i*9 +: 9]), .bf_data(bf_data[i*14 +: 14])
        );
    end

    obj_rom_arb u_arb (
        .clk, .rst, .obj_cs, .obj_addr, .obj_ok, .rom_cs, .rom_addr, .rom_ok
    );

    obj_line_buf u_buf (
        .clk, .rst, .hstart,
        .we(bf_we), .waddr(bf_addr), .wdata(bf_data),
        .rd_addr, .rd_data
    );

    assign done = &{scan_done, ~busy};   // Table walked, all units idle

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_tb -f tb.f -o obj_sim

out=$(./obj_dir/obj_sim)
echo "$out"

if grep -qF "** PASS **" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== tb.f ====
design/obj_pkg.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_rom_arb.sv
design/obj_line_buf.sv
design/obj_top.sv
tb/obj_tb.sv

// ==== tb/obj_tb.sv ====
// Sprite layer testbench running directed line tests against a ROM model and a reference painter
`default_nettype none

module obj_tb import obj_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_TESTS = 6;
    localparam logic [31:0] SEED      = 32'h5aff22cd;

    logic        clk, rst, hstart, tbl_we, rom_cs, rom_ok, done;
    logic [7:0]  vrender;
    logic [3:0]  tbl_addr;
    logic [63:0] tbl_wdata;
    logic [19:2] rom_addr;
    logic [31:0] rom_data;
    logic [8:0]  rd_addr;
    logic [13:0] rd_data;

    logic [31:0] rom [1 << 18];      // Graphics ROM, word addressed
    logic [63:0] tbl [NUM_SPR];      // Host copy of the sprite table
    logic [13:0] exp_line [LINE_W];
    logic        cs_end;             // rom_ok was high last cycle
    logic [1:0]  lat;                // Cycles left before rom_ok
    logic [7:0]  vline;
    int          fails, passes, errs;

    obj_top obj_top_i (.*);

    always #4 clk = ~clk;

    // ROM answers 1 to 4 cycles after chip select
    always @(posedge clk) begin
        if (cs_end && rom_cs) begin
            errs++;
            $display("ROM chip select still high the cycle after rom_ok");
        end
        cs_end <= rom_ok;
        if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (rom_cs) begin
            if (lat == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom[rom_addr];
                lat      <= 2'($urandom % 4);   // Latency of the next access
            end else begin
                lat <= lat - 2'd1;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 20000 * 8);
        $display("Watchdog expired, DUT did not finish the line in time");
        $display("** FAIL **");
        $finish;
    end

    // Row word address of an entry on the current line
    function automatic logic [17:0] row_addr(input logic [63:0] e);
        logic [7:0]  row;
        logic [15:0] ofs;
        row = vline - e[F_YPOS_LSB +: F_YPOS_W];
        ofs = e[F_OFFSET_LSB +: F_OFFSET_W] + 16'(row) * 16'(e[F_STRIDE_LSB +: F_STRIDE_W]);
        return {e[F_BANK_LSB +: F_BANK_W], ofs};
    endfunction

    function automatic logic on_line(input logic [63:0] e);
        logic [7:0] row;
        row = vline - e[F_YPOS_LSB +: F_YPOS_W];
        return e[F_ENABLE] && row < e[F_HEIGHT_LSB +: F_HEIGHT_W];
    endfunction

    // Random pixel word with the last drawn pixel forced to end or continue
    function automatic logic [31:0] make_word(input logic last, input logic hf);
        logic [31:0] w;
        logic [3:0]  tail;
        w    = $urandom;
        tail = last ? TRANSP : (hf ? w[31:28] : w[3:0]) & 4'h7;
        if (hf) w[31:28] = tail;
        else    w[3:0]   = tail;
        return w;
    endfunction

    task automatic add_sprite(input int ent, en, y, h, x, ofs, bank, stride, prio, pal,
                              input int zoom, hf, bw, sh, nwords);
        logic [63:0] w;
        logic [17:0] a;
        w = '0;
        w[F_YPOS_LSB +: F_YPOS_W]     = 8'(y);
        w[F_HEIGHT_LSB +: F_HEIGHT_W] = 8'(h);
        w[F_XPOS_LSB +: F_XPOS_W]     = 9'(x);
        w[F_OFFSET_LSB +: F_OFFSET_W] = 16'(ofs);
        w[F_BANK_LSB +: F_BANK_W]     = 2'(bank);
        w[F_STRIDE_LSB +: F_STRIDE_W] = 3'(stride);
        w[F_PRIO_LSB +: F_PRIO_W]     = 2'(prio);
        w[F_PAL_LSB +: F_PAL_W]       = 7'(pal);
        w[F_HZOOM_LSB +: F_HZOOM_W]   = 5'(zoom);
        w[F_SHADOW] = sh[0];
        w[F_HFLIP]  = hf[0];
        w[F_BACKWD] = bw[0];
        w[F_ENABLE] = en[0];
        tbl[ent]    = w;
        a = row_addr(w);
        for (int i = 0; i < nwords; i++) begin
            rom[a] = make_word(i == nwords - 1, hf[0]);
            a[15:0] = hf[0] ? a[15:0] - 16'd1 : a[15:0] + 16'd1;
        end
    endtask

    // Reference painter for one entry with the priority rule
    task automatic paint(input logic [63:0] e);
        logic [17:0] a;
        logic [31:0] w;
        logic [8:0]  pos;
        logic [5:0]  acc;
        logic [6:0]  sum;
        logic [3:0]  px;
        logic [4:0]  zoom;
        logic [13:0] val;
        logic        hf, last;
        int          guard;
        if (!on_line(e)) return;
        a     = row_addr(e);
        hf    = e[F_HFLIP];
        zoom  = e[F_HZOOM_LSB +: F_HZOOM_W];
        acc   = {zoom[3:0], 2'b00};
        pos   = e[F_XPOS_LSB +: F_XPOS_W];
        last  = 1'b0;
        guard = 0;
        while (!last && guard < 64) begin
            w = rom[a];
            for (int j = 0; j < 8; j++) begin
                px  = hf ? w[4*j +: 4] : w[28-4*j +: 4];
                sum = {1'b0, acc} + {2'b00, zoom};
                acc = sum[5:0];
                if (!sum[6]) begin     // Carry skips the pixel
                    val = {e[F_PAL_LSB +: F_PAL_W], e[F_SHADOW], e[F_PRIO_LSB +: 2], px};
                    if (px != TRANSP && (exp_line[pos][3:0] == TRANSP
                                         || val[5:4] >= exp_line[pos][5:4]))
                        exp_line[pos] = val;
                    pos = e[F_BACKWD] ? pos - 9'd1 : pos + 9'd1;
                end
                if (j == 7) last = px == TRANSP;
            end
            a[15:0] = hf ? a[15:0] - 16'd1 : a[15:0] + 16'd1;
            guard++;
        end
    endtask

    task automatic write_table(input logic blank);
        for (int i = 0; i < NUM_SPR; i++) begin
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_addr  <= 4'(i);
            tbl_wdata <= blank ? 64'd0 : tbl[i];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    task automatic pulse_hstart();
        @(posedge clk);
        hstart  <= 1'b1;
        vrender <= vline;
        rd_addr <= '0;
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) @(negedge clk);
    endtask

    // Streams the read half and expects it empty when blank is set
    task automatic read_line(input logic blank);
        logic [13:0] e;
        for (int a = 0; a < LINE_W; a++) begin
            @(posedge clk);
            rd_addr <= 9'(a + 1);
            @(negedge clk);
            e = blank ? {10'd0, TRANSP} : exp_line[a];
            if (e[3:0] == TRANSP ? rd_data[3:0] != TRANSP : rd_data != e) begin
                errs++;
                $display("FAILED rd_data at %h: got %h expected %h", 9'(a), rd_data, e);
            end
        end
    endtask

    task automatic run_line(input string name);
        errs = 0;
        write_table(1'b0);
        pulse_hstart();
        wait_done();
        foreach (exp_line[a]) exp_line[a] = {10'd0, TRANSP};
        for (int i = 0; i < NUM_SPR; i++) paint(tbl[i]);
        write_table(1'b1);
        pulse_hstart();
        read_line(1'b0);
        read_line(1'b1);     // Second pass must see a cleared half
        wait_done();
        if (errs == 0) passes++;
        else fails++;
        $display("test %s %s, %0d errors", name, errs == 0 ? "passed" : "failed", errs);
        foreach (tbl[i]) tbl[i] = '0;
    endtask

    task automatic single_sprite();
        logic [17:0] a;
        vline = 8'd50;
        add_sprite(0, 1, 40, 20, 100, 'h100, 1, 2, 1, 5, 0, 0, 0, 0, 2);
        a = row_addr(tbl[0]);
        rom[a]      = 32'h1234_f567;    // Gap in the middle
        rom[a + 1]  = 32'h89ff_abcf;    // End marker in the last nibble
        run_line("single");
    endtask

    task automatic flip_modes();
        vline = 8'd70;
        add_sprite(0, 1, 60, 30, 60, 'h400, 0, 3, 1, 9, 0, 1, 0, 0, 3);
        add_sprite(3, 1, 60, 30, 160, 'h800, 2, 3, 2, 10, 0, 0, 1, 0, 3);
        add_sprite(6, 1, 60, 30, 260, 'hc00, 3, 3, 3, 11, 0, 1, 1, 1, 3);
        add_sprite(9, 1, 60, 30, 360, 'h1000, 1, 3, 0, 12, 0, 0, 0, 0, 3);
        run_line("flips");
    endtask

    task automatic zoom_levels();
        vline = 8'd10;
        add_sprite(0, 1, 5, 10, 80, 'h2000, 0, 1, 1, 3, 0, 0, 0, 0, 3);
        add_sprite(4, 1, 5, 10, 200, 'h2100, 0, 1, 1, 4, 8, 1, 0, 0, 3);
        add_sprite(8, 1, 5, 10, 320, 'h2200, 0, 1, 1, 6, 31, 0, 1, 0, 3);
        run_line("zoom");
    endtask

    task automatic prio_overlap();
        vline = 8'd90;
        add_sprite(0, 1, 80, 20, 100, 'h3000, 0, 4, 2, 20, 0, 0, 0, 0, 3);
        add_sprite(1, 1, 80, 20, 110, 'h3100, 0, 4, 1, 21, 0, 0, 0, 0, 3);
        add_sprite(2, 1, 80, 20, 300, 'h3200, 1, 4, 3, 22, 0, 0, 0, 0, 1);
        add_sprite(3, 1, 80, 20, 405, 'h3300, 1, 4, 0, 23, 0, 0, 0, 0, 2);
        add_sprite(5, 1, 80, 20, 400, 'h3400, 2, 4, 2, 24, 0, 0, 0, 0, 2);
        add_sprite(14, 1, 80, 20, 306, 'h3500, 2, 4, 3, 25, 0, 0, 0, 0, 1);
        run_line("priority");
    endtask

    task automatic row_select();
        vline = 8'd120;
        add_sprite(0, 1, 130, 8, 40, 'h4000, 0, 2, 1, 30, 0, 0, 0, 0, 2);
        add_sprite(1, 1, 100, 10, 120, 'h4100, 0, 2, 1, 31, 0, 0, 0, 0, 2);
        add_sprite(2, 1, 110, 16, 200, 'h4200, 1, 3, 1, 32, 0, 0, 0, 0, 2);
        add_sprite(4, 1, 200, 180, 300, 'h4800, 2, 2, 1, 33, 0, 0, 0, 0, 2);
        add_sprite(6, 0, 110, 16, 420, 'h4f00, 0, 1, 1, 34, 0, 0, 0, 0, 2);
        run_line("vertical");
    endtask

    task automatic busy_crowd();
        int row;
        vline = 8'($urandom);
        for (int k = 0; k < 12; k++) begin
            row = $urandom % 16;
            add_sprite(k, 1, int'(vline) - row, row + 1 + $urandom % 20, 20 + 40 * k,
                       k * 1024 + $urandom % 512, $urandom % 4, 1 + $urandom % 7,
                       $urandom % 4, $urandom % 128, $urandom % 32, $urandom % 2,
                       $urandom % 2, $urandom % 2, 1 + $urandom % 2);
        end
        run_line("crowd");
    endtask

    initial begin
        void'($urandom(SEED));
        foreach (rom[a]) rom[a] = $urandom;
        foreach (tbl[i]) tbl[i] = '0;
        clk       = 1'b0;
        rst       = 1'b1;
        hstart    = 1'b0;
        vrender   = '0;
        tbl_we    = 1'b0;
        tbl_addr  = '0;
        tbl_wdata = '0;
        rom_ok    = 1'b0;
        rom_data  = '0;
        rd_addr   = '0;
        cs_end    = 1'b0;
        lat       = '0;
        vline     = '0;
        fails     = 0;
        passes    = 0;
        errs      = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        pulse_hstart();        // Empty first line brings done up
        wait_done();
        single_sprite();
        flip_modes();
        zoom_levels();
        prio_overlap();
        row_select();
        busy_crowd();
        $display("tests %0d, passed %0d, failed %0d", NUM_TESTS, passes, fails);
        if (fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
